// ==== src/mulPkg.sv ====
package mulPkg;

	// operand and product geometry.
	localparam int OperandWidth = 64;
	localparam int RowWidth = OperandWidth - 1; // width of one carry-save adder row.
	localparam int LastRow = OperandWidth - 1; // highest partial-product row index.

	// pipeline geometry.
	localparam int RowsPerStage = 16;
	localparam int NumCsaStages = 4;
	localparam int PipeLatency = 1 + NumCsaStages; // operand register plus carry-save registers.

	typedef logic [OperandWidth-1:0] operandT;
	typedef logic [OperandWidth-1:0] productT; // low half of the product.
	typedef logic [RowWidth-1:0] rowT; // running sum or carry row.

	// first partial-product row added by carry-save stage k.
	function automatic int stageFirstRow(input int k);
		return 1 + k * RowsPerStage;
	endfunction

	// rows added by carry-save stage k, clipped at the last row.
	function automatic int stageNumRows(input int k);
		int first;
		int remaining;
		first = stageFirstRow(k);
		remaining = LastRow - first + 1;
		if (remaining < RowsPerStage) begin
			return remaining;
		end
		return RowsPerStage;
	endfunction

endpackage

// ==== src/operandStage.sv ====
`timescale 1ns/10ps

module operandStage (
	input logic clk,
	input logic arstN,
	input logic validIn,
	input mulPkg::operandT a,
	input mulPkg::operandT b,
	output mulPkg::operandT aOut,
	output mulPkg::operandT bOut,
	output mulPkg::rowT sumOut,
	output mulPkg::rowT carryOut,
	output mulPkg::productT doneOut,
	output logic validOut
);

	mulPkg::operandT rowZero;
	mulPkg::productT doneNext;

	// partial-product row zero, a gated by the lowest bit of b.
	assign rowZero = a & {mulPkg::OperandWidth{b[0]}};

	always_comb begin
		doneNext = '0;
		doneNext[0] = rowZero[0]; // bit 0 of the product needs no adding.
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validOut <= 1'b0;
			aOut <= '0;
			bOut <= '0;
			sumOut <= '0;
			carryOut <= '0;
			doneOut <= '0;
		end else begin
			validOut <= validIn;
			if (validIn) begin
				aOut <= a;
				bOut <= b;
				sumOut <= rowZero[mulPkg::OperandWidth-1:1]; // already aligned to row one.
				carryOut <= '0;
				doneOut <= doneNext;
			end
		end
	end

	// the whole pipeline trusts this strobe, an X here would smear through every stage.
	validInKnown: assert property (
		@(posedge clk) disable iff (!arstN)
		!$isunknown(validIn)
	) else $error("validIn is unknown while out of reset.");

endmodule

// ==== src/csaStage.sv ====
`timescale 1ns/10ps

module csaStage #(
	parameter int FirstRow = 1,
	parameter int NumRows = mulPkg::RowsPerStage
) (
	input logic clk,
	input logic arstN,
	input logic validIn,
	input mulPkg::operandT aIn,
	input mulPkg::operandT bIn,
	input mulPkg::rowT sumIn,
	input mulPkg::rowT carryIn,
	input mulPkg::productT doneIn,
	output logic validOut,
	output mulPkg::operandT aOut,
	output mulPkg::operandT bOut,
	output mulPkg::rowT sumOut,
	output mulPkg::rowT carryOut,
	output mulPkg::productT doneOut
);

	localparam int Width = mulPkg::OperandWidth;
	localparam int RowW = mulPkg::RowWidth;

	// the rows of this stage must fit inside the array.
	if (FirstRow < 1 || NumRows < 1 || FirstRow + NumRows - 1 > mulPkg::LastRow) begin : gBadSplit
		$error("csaStage rows %0d..%0d fall outside the array.",
			FirstRow, FirstRow + NumRows - 1);
	end

	// sum and carry between adjacent rows, entry 0 is the stage input.
	mulPkg::rowT sumChain [NumRows+1];
	mulPkg::rowT carryChain [NumRows+1];
	logic [NumRows-1:0] retired; // finished product bits, one per row.
	mulPkg::productT doneNext;

	assign sumChain[0] = sumIn;
	assign carryChain[0] = carryIn;

	for (genvar i = 0; i < NumRows; i++) begin : gRow
		localparam int Row = FirstRow + i;

		mulPkg::operandT partial;
		mulPkg::rowT addendA;
		mulPkg::rowT addendB;
		mulPkg::rowT addendC;
		mulPkg::rowT rowSum;
		mulPkg::rowT rowCarry;

		assign partial = aIn & {Width{bIn[Row]}};

		// all three addends sit at weights Row up to Row+62.
		assign addendA = sumChain[i];
		assign addendB = partial[RowW-1:0];
		assign addendC = carryChain[i];

		// one 63-wide full-adder row.
		assign rowSum = addendA ^ addendB ^ addendC;
		assign rowCarry = (addendA & addendB) | (addendA & addendC) | (addendB & addendC);

		assign retired[i] = rowSum[0]; // weight Row, nothing later touches it.

		// shift out the retired bit; the top of this row's partial product fills in.
		assign sumChain[i+1] = {partial[Width-1], rowSum[RowW-1:1]};
		assign carryChain[i+1] = rowCarry; // carries already land one weight up.
	end

	always_comb begin
		doneNext = doneIn;
		for (int i = 0; i < NumRows; i++) begin
			doneNext[FirstRow + i] = retired[i];
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validOut <= 1'b0;
			aOut <= '0;
			bOut <= '0;
			sumOut <= '0;
			carryOut <= '0;
			doneOut <= '0;
		end else begin
			validOut <= validIn;
			if (validIn) begin
				aOut <= aIn; // operands ride along for the later rows.
				bOut <= bIn;
				sumOut <= sumChain[NumRows];
				carryOut <= carryChain[NumRows];
				doneOut <= doneNext;
			end
		end
	end

	// a bubble entering the stage leaves it as a bubble.
	bubbleStaysBubble: assert property (
		@(posedge clk) disable iff (!arstN)
		!validIn |=> !validOut
	) else $error("csaStage rows %0d+: validOut set after idle input.", FirstRow);

	// finished bits hold across idle cycles, which keeps product steady at the top.
	doneHeldWhenIdle: assert property (
		@(posedge clk) disable iff (!arstN)
		!validIn |=> $stable(doneOut)
	) else $error("csaStage rows %0d+: doneOut moved after idle input.", FirstRow);

endmodule

// ==== src/mulTop.sv ====
`timescale 1ns/10ps

module mulTop (
	input logic clk,
	input logic arstN,
	input mulPkg::operandT a,
	input mulPkg::operandT b,
	input logic validIn,
	output mulPkg::productT product,
	output logic productValid
);

	localparam int NumStages = mulPkg::NumCsaStages;

	// entry 0 comes from the operand register, entry k+1 from carry-save stage k.
	mulPkg::operandT aPipe [NumStages+1];
	mulPkg::operandT bPipe [NumStages+1];
	mulPkg::rowT sumPipe [NumStages+1];
	mulPkg::rowT carryPipe [NumStages+1];
	mulPkg::productT donePipe [NumStages+1];
	logic validPipe [NumStages+1];

	operandStage operandStage_inst (
		.clk(clk),
		.arstN(arstN),
		.validIn(validIn),
		.a(a),
		.b(b),
		.aOut(aPipe[0]),
		.bOut(bPipe[0]),
		.sumOut(sumPipe[0]),
		.carryOut(carryPipe[0]),
		.doneOut(donePipe[0]),
		.validOut(validPipe[0])
	);

	for (genvar k = 0; k < NumStages; k++) begin : gStage
		csaStage #(
			.FirstRow(mulPkg::stageFirstRow(k)), // rows 1, 17, 33 and 49.
			.NumRows(mulPkg::stageNumRows(k)) // last stage stops at row 63.
		) csaStage_inst (
			.clk(clk),
			.arstN(arstN),
			.validIn(validPipe[k]),
			.aIn(aPipe[k]),
			.bIn(bPipe[k]),
			.sumIn(sumPipe[k]),
			.carryIn(carryPipe[k]),
			.doneIn(donePipe[k]),
			.validOut(validPipe[k+1]),
			.aOut(aPipe[k+1]),
			.bOut(bPipe[k+1]),
			.sumOut(sumPipe[k+1]),
			.carryOut(carryPipe[k+1]),
			.doneOut(donePipe[k+1])
		);
	end

	// every product bit has retired by the end of the last stage.
	assign product = donePipe[NumStages];
	assign productValid = validPipe[NumStages];

endmodule

// ==== sim/tbClock.sv ====
`timescale 1ns/10ps

module tbClock #(
	parameter real PeriodNs = 8.0,
	parameter int ResetCycles = 3
) (
	output logic clk,
	output logic arstN
);

	initial begin
		clk = 1'b0;
		forever #(PeriodNs / 2.0) clk = ~clk;
	end

	// release away from the rising edge.
	initial begin
		arstN = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
	end

endmodule

// ==== sim/mulTb.sv ====
`timescale 1ns/10ps

module mulTb;

	localparam int Width = mulPkg::OperandWidth;
	localparam int Latency = mulPkg::PipeLatency;
	localparam int ThroughputPairs = 200;
	localparam int GapPairs = 60;
	localparam int MaxGap = 3;
	// isolated pairs cost about Latency+3 cycles each, streams one cycle per pair plus gaps.
	localparam int RunCycles = 24 * (Latency + 3) + ThroughputPairs
		+ GapPairs * (MaxGap + 1) + 60;
	localparam int TimeoutCycles = 3 * RunCycles; // roughly 2000 cycles.

	logic clk;
	logic arstN;
	logic validIn = 1'b0;
	mulPkg::operandT a;
	mulPkg::operandT b;
	mulPkg::productT product;
	logic productValid;

	mulPkg::productT expQueue [$]; // one entry per accepted pair, oldest first.
	mulPkg::productT expected = '0; // model value of the latest pulse.
	logic pulseMatched = 1'b0;
	logic [31:0] lcgState = 32'he371e338;
	int pairsAccepted;
	int pulsesSeen;
	int failCount;
	int testsRun;
	int testsFailed;
	int cycleCount;
	int testErrStart;
	int testPairStart;
	int testPulseStart;

	tbClock tbClock_inst (
		.clk(clk),
		.arstN(arstN)
	);

	mulTop mulTop_inst (
		.clk(clk),
		.arstN(arstN),
		.a(a),
		.b(b),
		.validIn(validIn),
		.product(product),
		.productValid(productValid)
	);

	// low half of the full double-width product.
	function automatic mulPkg::productT modelProduct(input mulPkg::operandT x,
		input mulPkg::operandT y);
		logic [2*Width-1:0] full;
		full = {{Width{1'b0}}, x} * {{Width{1'b0}}, y};
		return full[Width-1:0];
	endfunction

	function automatic logic [31:0] lcgStep(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic randomOperand(output mulPkg::operandT value);
		logic [31:0] upper;
		lcgState = lcgStep(lcgState);
		upper = lcgState;
		lcgState = lcgStep(lcgState);
		value = {upper, lcgState};
	endtask

	task automatic randomGap(output int gap);
		lcgState = lcgStep(lcgState);
		gap = {30'd0, lcgState[17:16]}; // upper bits, the low ones cycle fast.
	endtask

	// called on a falling edge, returns on the next one.
	task automatic sendPair(input mulPkg::operandT x, input mulPkg::operandT y);
		validIn = 1'b1;
		a = x;
		b = y;
		@(negedge clk);
	endtask

	// idle cycles carry junk operands that must not reach product.
	task automatic idleCycles(input int n);
		mulPkg::operandT junkA;
		mulPkg::operandT junkB;
		for (int i = 0; i < n; i++) begin
			randomOperand(junkA);
			randomOperand(junkB);
			validIn = 1'b0;
			a = junkA;
			b = junkB;
			@(negedge clk);
		end
	endtask

	task automatic sendRandom();
		mulPkg::operandT x;
		mulPkg::operandT y;
		randomOperand(x);
		randomOperand(y);
		sendPair(x, y);
	endtask

	// wait until every outstanding result has come out and been checked.
	task automatic drainPipe();
		validIn = 1'b0;
		while (expQueue.size() != 0) begin
			@(negedge clk);
		end
		@(negedge clk); // the check of the last pulse runs on the edge in between.
	endtask

	task automatic startTest();
		testErrStart = failCount;
		testPairStart = pairsAccepted;
		testPulseStart = pulsesSeen;
	endtask

	task automatic finishTest(input string name);
		int pairs;
		int pulses;
		int errs;
		drainPipe();
		pairs = pairsAccepted - testPairStart;
		pulses = pulsesSeen - testPulseStart;
		pulseCount: assert (pulses == pairs) else begin
			$display("test %s: %0d pairs went in but %0d results came out",
				name, pairs, pulses);
			failCount++;
		end
		errs = failCount - testErrStart;
		testsRun++;
		if (errs != 0) begin
			testsFailed++;
		end
		$display("test %s: %0d pairs, %0d errors", name, pairs, errs);
	endtask

	// model side of the scoreboard, fed by what the DUT samples.
	always @(posedge clk) begin
		if (arstN && validIn) begin
			expQueue.push_back(modelProduct(a, b));
			pairsAccepted++;
		end
	end

	// outputs are settled at the falling edge.
	always @(negedge clk) begin
		if (arstN && productValid) begin
			pulsesSeen++;
			if (expQueue.size() != 0) begin
				expected = expQueue.pop_front();
				pulseMatched = 1'b1;
			end else begin
				pulseMatched = 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
	end

	initial begin : watchdog
		wait (cycleCount >= TimeoutCycles);
		$display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
		$display("** FAIL **");
		$finish;
	end

	// one pulse per accepted pair, exactly Latency edges after its sampling edge.
	latencyCheck: assert property (
		@(posedge clk) disable iff (!arstN)
		productValid == $past(validIn, Latency)
	) else begin
		$display("Mismatch at %0t: productValid expected %b, got %b", $time,
			!$sampled(productValid), $sampled(productValid));
		failCount++;
	end

	pulseHasPair: assert property (
		@(posedge clk) disable iff (!arstN)
		productValid |-> pulseMatched
	) else begin
		$display("at %0t productValid pulsed with no pair outstanding", $time);
		failCount++;
	end

	productCheck: assert property (
		@(posedge clk) disable iff (!arstN)
		productValid && pulseMatched |-> product == expected
	) else begin
		$display("Mismatch at %0t: product expected %h, got %h", $time,
			$sampled(expected), $sampled(product));
		failCount++;
	end

	holdCheck: assert property (
		@(posedge clk) disable iff (!arstN)
		!productValid |-> product == expected
	) else begin
		$display("Mismatch at %0t: product expected %h (held), got %h", $time,
			$sampled(expected), $sampled(product));
		failCount++;
	end

	initial begin
		int gap;
		validIn = 1'b0;
		a = '0;
		b = '0;
		@(posedge arstN);
		@(negedge clk);

		// nothing may come out before the first pair.
		startTest();
		idleCycles(12);
		sendRandom();
		finishTest("reset quiet");

		startTest();
		sendPair('0, 64'hdeadbeefcafef00d);
		idleCycles(2);
		sendPair(64'h123456789abcdef0, '0);
		idleCycles(2);
		sendPair(64'd1, 64'd1);
		idleCycles(2);
		sendPair(64'd2, 64'd1);
		idleCycles(2);
		sendPair(64'd1, 64'd2);
		idleCycles(2);
		sendPair(64'd16, 64'd16);
		idleCycles(2);
		sendPair(64'hfffffffffffffffd, 64'd7); // -3 times 7.
		idleCycles(2);
		sendPair(64'h8000000000000000, 64'd2); // wraps to zero.
		idleCycles(2);
		sendPair(64'h0123456789abcdef, 64'hfedcba9876543210);
		idleCycles(2);
		sendPair(64'h00000000ffffffff, 64'h00000000ffffffff);
		idleCycles(2);
		sendPair(64'h7fffffffffffffff, 64'hffffffffffffffff);
		idleCycles(2);
		sendPair('1, '1); // gives 1.
		idleCycles(2);
		sendPair(64'd1, '1);
		finishTest("directed");

		startTest();
		for (int i = 0; i < 3; i++) begin
			sendRandom();
			idleCycles(Latency + 2);
		end
		sendRandom();
		sendRandom();
		finishTest("latency");

		// back to back, five pairs in flight.
		startTest();
		for (int i = 0; i < ThroughputPairs; i++) begin
			sendRandom();
		end
		finishTest("throughput");

		startTest();
		for (int i = 0; i < GapPairs; i++) begin
			sendRandom();
			randomGap(gap);
			idleCycles(gap);
		end
		finishTest("gaps");

		$display("tests %0d, failed %0d, pairs %0d, errors %0d",
			testsRun, testsFailed, pairsAccepted, failCount);
		if (failCount == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== build.f ====
src/mulPkg.sv
src/operandStage.sv
src/csaStage.sv
src/mulTop.sv
sim/tbClock.sv
sim/mulTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= mulTb
FILELIST ?= build.f
OBJDIR ?= obj_dir
LOG ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "simulator exited with status $$status"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
